//--- xversat.f
hdl/xversat_cfg_pkg.sv
hdl/xversat_bus_pkg.sv
hdl/cfg_split.sv
hdl/xyolo_read.sv
hdl/xyolo_write.sv
hdl/databus_arbiter.sv
hdl/xversat.sv
sim/tb_mem_model.sv
sim/tb_xversat.sv

//--- Bender.yml
package:
  name: xversat

sources:
  - hdl/xversat_cfg_pkg.sv
  - hdl/xversat_bus_pkg.sv
  - hdl/cfg_split.sv
  - hdl/xyolo_read.sv
  - hdl/xyolo_write.sv
  - hdl/databus_arbiter.sv
  - hdl/xversat.sv
  - target: simulation
    files:
      - sim/tb_mem_model.sv
      - sim/tb_xversat.sv

//--- sim/tb_xversat.sv
`timescale 1ns/1ps
`default_nettype none

module tb_xversat import xversat_cfg_pkg::*; ();

   localparam int ADDR_W     = 32;
   localparam int DATA_W     = 32;
   localparam int DATAPATH_W = 16;
   localparam int N_MACS     = 4;
   localparam int DEPTH_W    = 8;
   localparam int MEM_WORDS  = 2**DEPTH_W;
   localparam int N_ROWS     = 3;
   localparam int MAX_OUT    = 3;
   localparam int TIMEOUT    = 2000;

   // memory layout used by every row
   localparam int BIAS_BASE   = 16;
   localparam int WEIGHT_BASE = 32;
   localparam int IN_BASE     = 64;
   localparam int OUT_BASE    = 128;

   localparam logic [ADDR_W-1:0] RUN_ADDR   = 32'h8000_0000;
   localparam logic [ADDR_W-1:0] CLEAR_ADDR = 32'hC000_0000;

   logic              clk;
   logic              rst;
   logic              valid;
   logic [ADDR_W-1:0] addr;
   logic              wstrb;
   logic [DATA_W-1:0] wdata;
   wire               ready;
   wire  [DATA_W-1:0] rdata;
   wire               mem_valid;
   wire  [DATA_W-1:0] mem_addr;
   wire  [DATA_W-1:0] mem_wdata;
   wire               mem_wstrb;
   wire  [DATA_W-1:0] mem_rdata;
   wire               mem_ready;
   logic              stall;
   logic              random_lat;
   logic [15:0]       lfsr;
   logic [DATA_W-1:0] image [MEM_WORDS];

   // test table with results computed by hand in 16 bit wraparound
   int bias_tbl [N_ROWS]                = '{5, -100, 30000};
   int w_tbl    [N_ROWS][N_MACS]        = '{'{1, 2, 3, 4}, '{-3, 7, 0, 2}, '{300, 1, 0, -1}};
   int x_tbl    [N_ROWS][MAX_OUT*N_MACS] = '{
      '{1, 2, 3, 4, 5, 6, 7, 8, 0, 0, 0, 0},
      '{10, 20, 30, 40, -5, -6, -7, -8, 100, -100, 50, 0},
      '{300, 5000, 9, 1234, 0, 0, 0, 0, 0, 0, 0, 0}
   };
   int n_tbl    [N_ROWS]                = '{2, 3, 1};
   int exp_tbl  [N_ROWS][MAX_OUT]       = '{'{35, 75, 0}, '{90, -143, -1100}, '{-7306, 0, 0}};

   xversat #(
      .ADDR_W    (ADDR_W),
      .DATA_W    (DATA_W),
      .DATAPATH_W(DATAPATH_W),
      .N_MACS    (N_MACS)
   ) u_dut (
      .clk       (clk),
      .rst       (rst),
      .valid     (valid),
      .addr      (addr),
      .wstrb     (wstrb),
      .wdata     (wdata),
      .ready     (ready),
      .rdata     (rdata),
      .mem_valid (mem_valid),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_wstrb (mem_wstrb),
      .mem_rdata (mem_rdata),
      .mem_ready (mem_ready)
   );

   tb_mem_model #(
      .DATA_W (DATA_W),
      .DEPTH_W(DEPTH_W)
   ) u_mem (
      .clk       (clk),
      .stall     (stall),
      .mem_valid (mem_valid),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_wstrb (mem_wstrb),
      .mem_rdata (mem_rdata),
      .mem_ready (mem_ready)
   );

   always #50 clk = ~clk;

   task automatic abort_run(input string line);
      $display("%s", line);
      $display("Simulation finished: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      if (s[0])
         return (s >> 1) ^ 16'hB400;
      return s >> 1;
   endfunction

   // one latency bit per cycle
   always @(posedge clk) begin
      #1;
      if (random_lat) begin
         stall = lfsr[0];
         lfsr  = lfsr_next(lfsr);
      end else begin
         stall = 1'b0;
      end
   end

   always @(posedge clk) begin
      if (!rst && mem_valid)
         assert (mem_addr < MEM_WORDS)
            else abort_run($sformatf("Memory access outside the model at address %h", mem_addr));
   end

   function automatic logic [DATA_W-1:0] fill_word(input logic [DATA_W-1:0] a);
      return 32'h5A00_0000 ^ (a << 12) ^ (a * 32'h0000_0103);
   endfunction

   function automatic logic [ADDR_W-1:0] config_address(input logic [1:0] unit,
                                                        input logic [3:0] idx);
      return {1'b0, unit, 25'b0, idx};
   endfunction

   task automatic cpu_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
      @(posedge clk);
      #1;
      valid = 1'b1;
      addr  = a;
      wstrb = 1'b1;
      wdata = d;
      assert (ready === 1'b1)
         else abort_run($sformatf("Mismatch at %0t ns: ready %b during cpu write", $time, ready));
      @(posedge clk);
      #1;
      valid = 1'b0;
      addr  = '0;
      wstrb = 1'b0;
      wdata = '0;
   endtask

   task automatic load_memory(input int row);
      for (int i = 0; i < MEM_WORDS; i++)
         image[i] = fill_word(i);
      image[BIAS_BASE] = bias_tbl[row];
      for (int i = 0; i < N_MACS; i++)
         image[WEIGHT_BASE + i] = w_tbl[row][i];
      for (int i = 0; i < n_tbl[row] * N_MACS; i++)
         image[IN_BASE + i] = x_tbl[row][i];
      for (int i = 0; i < MEM_WORDS; i++)
         u_mem.mem[i] = image[i];
   endtask

   task automatic configure(input int row);
      cpu_write(config_address(UNIT_READ, REG_BIAS_ADDR), BIAS_BASE);
      cpu_write(config_address(UNIT_READ, REG_WEIGHT_ADDR), WEIGHT_BASE);
      cpu_write(config_address(UNIT_WRITE, REG_IN_ADDR), IN_BASE);
      cpu_write(config_address(UNIT_WRITE, REG_OUT_ADDR), OUT_BASE);
      cpu_write(config_address(UNIT_WRITE, REG_N_OUT), n_tbl[row]);
   endtask

   // run pulse lands two cycles after the write and drops done
   task automatic start_run();
      cpu_write(RUN_ADDR, '0);
      repeat (2) @(posedge clk);
      #1;
      assert (rdata === '0)
         else abort_run($sformatf("Mismatch at %0t ns: rdata %h while busy", $time, rdata));
   endtask

   task automatic wait_done(input int limit);
      int   n;
      logic seen;
      n    = 0;
      seen = 1'b0;
      while (!seen && n < limit) begin
         @(posedge clk);
         #1;
         n++;
         assert (rdata[DATA_W-1:1] === '0)
            else abort_run($sformatf("Mismatch at %0t ns: rdata upper bits %h", $time, rdata));
         if (rdata[0] === 1'b1)
            seen = 1'b1;
      end
      if (!seen)
         abort_run($sformatf("Timeout: done did not rise within %0d cycles", limit));
   endtask

   task automatic check_memory(input int row);
      logic [DATA_W-1:0] want;
      for (int i = 0; i < MEM_WORDS; i++) begin
         if (i >= OUT_BASE && i < OUT_BASE + n_tbl[row])
            want = exp_tbl[row][i - OUT_BASE];
         else
            want = image[i];
         assert (u_mem.mem[i] === want)
            else abort_run($sformatf("Mismatch at %0t ns: row %0d mem[%0d] = %h, expected %h",
                                     $time, row, i, u_mem.mem[i], want));
      end
   endtask

   task automatic run_case(input int row, input logic rand_mode);
      random_lat = rand_mode;
      load_memory(row);
      configure(row);
      start_run();
      wait_done(TIMEOUT);
      check_memory(row);
   endtask

   task automatic clear_units();
      cpu_write(CLEAR_ADDR, '0);
      assert (rdata === '0)
         else abort_run($sformatf("Mismatch at %0t ns: rdata %h after clear", $time, rdata));
   endtask

   initial begin
      clk        = 1'b0;
      rst        = 1'b1;
      valid      = 1'b0;
      addr       = '0;
      wstrb      = 1'b0;
      wdata      = '0;
      stall      = 1'b0;
      random_lat = 1'b0;
      lfsr       = 16'd58974;
      repeat (2) @(posedge clk);
      #1;
      rst = 1'b0;
      assert (mem_valid === 1'b0 && rdata === '0)
         else abort_run($sformatf("Mismatch at %0t ns: bus or done active after reset", $time));
      // zero wait and random latency runs followed by a clear and a rerun
      for (int row = 0; row < N_ROWS; row++) begin
         run_case(row, 1'b0);
         run_case(row, 1'b1);
         clear_units();
         run_case(row, 1'b1);
      end
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

`default_nettype wire

//--- sim/tb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model #(
   parameter int DATA_W  = 32,
   parameter int DEPTH_W = 8
) (
   input  wire                clk,
   input  wire                stall,
   input  wire                mem_valid,
   input  wire   [DATA_W-1:0] mem_addr,
   input  wire   [DATA_W-1:0] mem_wdata,
   input  wire                mem_wstrb,
   output logic  [DATA_W-1:0] mem_rdata,
   output logic               mem_ready
);

   logic [DATA_W-1:0]  mem [2**DEPTH_W];
   logic [DEPTH_W-1:0] idx;

   assign idx = mem_addr[DEPTH_W-1:0];

   // a stalled cycle just holds the request
   assign mem_ready = mem_valid & ~stall;

   // read data only meaningful in the ready cycle
   assign mem_rdata = mem_ready ? mem[idx] : 'x;

   always @(posedge clk) begin
      if (mem_valid && mem_ready && mem_wstrb)
         mem[idx] <= mem_wdata;
   end

endmodule

`default_nettype wire

//--- hdl/xversat.sv
`timescale 1ns/1ps
`default_nettype none

module xversat import xversat_cfg_pkg::*; import xversat_bus_pkg::*; #(
   parameter int ADDR_W     = 32,
   parameter int DATA_W     = 32,
   parameter int DATAPATH_W = 16,
   parameter int N_MACS     = 4
) (
   input  wire                clk,
   input  wire                rst,
   // cpu port
   input  wire                valid,
   input  wire   [ADDR_W-1:0] addr,
   input  wire                wstrb,
   input  wire   [DATA_W-1:0] wdata,
   output logic               ready,
   output logic  [DATA_W-1:0] rdata,
   // native memory port
   output logic               mem_valid,
   output logic  [DATA_W-1:0] mem_addr,
   output logic  [DATA_W-1:0] mem_wdata,
   output logic               mem_wstrb,
   input  wire   [DATA_W-1:0] mem_rdata,
   input  wire                mem_ready
);

   logic                         cfg_valid_read;
   logic                         cfg_valid_write;
   logic [REG_IDX_W-1:0]         cfg_addr;
   logic [DATA_W-1:0]            cfg_wdata;
   logic                         run;
   logic                         clear;
   logic                         read_done;
   logic                         write_done;
   logic [DATAPATH_W-1:0]        flow_bias;
   logic [N_MACS*DATAPATH_W-1:0] flow_weight;

   // databus, one slice per requester
   wire  [N_REQ-1:0]             req_valid;
   wire  [N_REQ-1:0]             req_ready;
   wire  [N_REQ-1:0]             req_wstrb;
   wire  [N_REQ*DATA_W-1:0]      req_addr;
   wire  [N_REQ*DATA_W-1:0]      req_wdata;
   wire  [DATA_W-1:0]            req_rdata;

   // write-only cpu port, done is the only readback
   assign ready = 1'b1;
   assign rdata = {{(DATA_W-1){1'b0}}, read_done & write_done};

   // input fetch only reads, result port only writes
   assign req_wstrb[PORT_WRITE_RD] = 1'b0;
   assign req_wdata[PORT_WRITE_RD*DATA_W +: DATA_W] = '0;
   assign req_wstrb[PORT_WRITE_WR] = 1'b1;

   cfg_split #(
      .ADDR_W(ADDR_W),
      .DATA_W(DATA_W)
   ) u_cfg_split (
      .clk             (clk),
      .rst             (rst),
      .valid           (valid),
      .addr            (addr),
      .wstrb           (wstrb),
      .wdata           (wdata),
      .cfg_valid_read  (cfg_valid_read),
      .cfg_valid_write (cfg_valid_write),
      .cfg_addr        (cfg_addr),
      .cfg_wdata       (cfg_wdata),
      .run             (run),
      .clear           (clear)
   );

   xyolo_read #(
      .DATA_W    (DATA_W),
      .DATAPATH_W(DATAPATH_W),
      .N_MACS    (N_MACS)
   ) u_xyolo_read (
      .clk             (clk),
      .rst             (rst),
      .clear           (clear),
      .run             (run),
      .cfg_valid       (cfg_valid_read),
      .cfg_addr        (cfg_addr),
      .cfg_wdata       (cfg_wdata),
      .done            (read_done),
      .db_valid        (req_valid[PORT_READ]),
      .db_addr         (req_addr[PORT_READ*DATA_W +: DATA_W]),
      .db_wdata        (req_wdata[PORT_READ*DATA_W +: DATA_W]),
      .db_wstrb        (req_wstrb[PORT_READ]),
      .db_ready        (req_ready[PORT_READ]),
      .db_rdata        (req_rdata),
      .flow_out_bias   (flow_bias),
      .flow_out_weight (flow_weight)
   );

   xyolo_write #(
      .DATA_W    (DATA_W),
      .DATAPATH_W(DATAPATH_W),
      .N_MACS    (N_MACS)
   ) u_xyolo_write (
      .clk             (clk),
      .rst             (rst),
      .clear           (clear),
      .run             (run),
      .cfg_valid       (cfg_valid_write),
      .cfg_addr        (cfg_addr),
      .cfg_wdata       (cfg_wdata),
      .done            (write_done),
      .flow_in_bias    (flow_bias),
      .flow_in_weight  (flow_weight),
      .flow_in_done    (read_done),
      .rd_valid        (req_valid[PORT_WRITE_RD]),
      .rd_addr         (req_addr[PORT_WRITE_RD*DATA_W +: DATA_W]),
      .rd_ready        (req_ready[PORT_WRITE_RD]),
      .rd_rdata        (req_rdata),
      .wr_valid        (req_valid[PORT_WRITE_WR]),
      .wr_addr         (req_addr[PORT_WRITE_WR*DATA_W +: DATA_W]),
      .wr_wdata        (req_wdata[PORT_WRITE_WR*DATA_W +: DATA_W]),
      .wr_ready        (req_ready[PORT_WRITE_WR])
   );

   databus_arbiter #(
      .DATA_W(DATA_W)
   ) u_databus_arbiter (
      .clk       (clk),
      .rst       (rst),
      .req_valid (req_valid),
      .req_addr  (req_addr),
      .req_wdata (req_wdata),
      .req_wstrb (req_wstrb),
      .req_ready (req_ready),
      .req_rdata (req_rdata),
      .mem_valid (mem_valid),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_wstrb (mem_wstrb),
      .mem_rdata (mem_rdata),
      .mem_ready (mem_ready)
   );

endmodule

`default_nettype wire

//--- hdl/databus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module databus_arbiter import xversat_bus_pkg::*; #(
   parameter int DATA_W = 32
) (
   input  wire                     clk,
   input  wire                     rst,
   input  wire  [N_REQ-1:0]        req_valid,
   input  wire  [N_REQ*DATA_W-1:0] req_addr,
   input  wire  [N_REQ*DATA_W-1:0] req_wdata,
   input  wire  [N_REQ-1:0]        req_wstrb,
   output logic [N_REQ-1:0]        req_ready,
   output logic [DATA_W-1:0]       req_rdata,
   output logic                    mem_valid,
   output logic [DATA_W-1:0]       mem_addr,
   output logic [DATA_W-1:0]       mem_wdata,
   output logic                    mem_wstrb,
   input  wire  [DATA_W-1:0]       mem_rdata,
   input  wire                     mem_ready
);

   localparam int PTR_W = (N_REQ > 1) ? $clog2(N_REQ) : 1;

   logic [PTR_W-1:0] last_q;
   logic [PTR_W-1:0] gnt_q;
   logic [PTR_W-1:0] rr_sel;
   logic [PTR_W-1:0] sel;
   logic             rr_found;
   logic             locked;

   // search starts just after the last granted requester
   always_comb begin
      int unsigned idx;
      rr_sel   = last_q;
      rr_found = 1'b0;
      for (int k = 1; k <= N_REQ; k++) begin
         idx = int'(last_q) + k;
         if (idx >= N_REQ)
            idx = idx - N_REQ;
         if (!rr_found && req_valid[idx]) begin
            rr_found = 1'b1;
            rr_sel   = PTR_W'(idx);
         end
      end
   end

   assign sel       = locked ? gnt_q : rr_sel;
   assign mem_valid = req_valid[sel];
   assign mem_addr  = req_addr[sel*DATA_W +: DATA_W];
   assign mem_wdata = req_wdata[sel*DATA_W +: DATA_W];
   assign mem_wstrb = req_wstrb[sel];
   assign req_rdata = mem_rdata;

   always_comb begin
      req_ready      = '0;
      req_ready[sel] = mem_valid & mem_ready;
   end

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         locked <= 1'b0;
         gnt_q  <= '0;
         last_q <= PTR_W'(N_REQ - 1);
      end else begin
         locked <= mem_valid & ~mem_ready;
         gnt_q  <= sel;
         if (mem_valid && mem_ready)
            last_q <= sel;
      end
   end

   ready_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(req_ready))
      else $error("more than one requester acknowledged");

endmodule

`default_nettype wire

//--- hdl/xyolo_write.sv
`timescale 1ns/1ps
`default_nettype none

module xyolo_write import xversat_cfg_pkg::*; #(
   parameter int DATA_W     = 32,
   parameter int DATAPATH_W = 16,
   parameter int N_MACS     = 4
) (
   input  wire                          clk,
   input  wire                          rst,
   input  wire                          clear,
   input  wire                          run,
   input  wire                          cfg_valid,
   input  wire  [REG_IDX_W-1:0]         cfg_addr,
   input  wire  [DATA_W-1:0]            cfg_wdata,
   output logic                         done,
   input  wire  [DATAPATH_W-1:0]        flow_in_bias,
   input  wire  [N_MACS*DATAPATH_W-1:0] flow_in_weight,
   input  wire                          flow_in_done,
   output logic                         rd_valid,
   output logic [DATA_W-1:0]            rd_addr,
   input  wire                          rd_ready,
   input  wire  [DATA_W-1:0]            rd_rdata,
   output logic                         wr_valid,
   output logic [DATA_W-1:0]            wr_addr,
   output logic [DATA_W-1:0]            wr_wdata,
   input  wire                          wr_ready
);

   localparam int CNT_W = $clog2(N_MACS + 1);

   logic [DATA_W-1:0]              in_base;
   logic [DATA_W-1:0]              out_base;
   logic [DATA_W-1:0]              n_out;
   logic [DATA_W-1:0]              in_ptr;
   logic [DATA_W-1:0]              out_ptr;
   logic [DATA_W-1:0]              rd_out_cnt;
   logic [DATA_W-1:0]              wr_cnt;
   logic [CNT_W-1:0]               mac_cnt;
   logic                           active;
   logic                           started;
   logic                           res_full;
   logic                           last_mac;
   logic                           rd_fire;
   logic                           wr_fire;
   logic signed [DATAPATH_W-1:0]   mac_w;
   logic signed [DATAPATH_W-1:0]   mac_x;
   logic signed [DATAPATH_W-1:0]   mac_base;
   logic signed [DATAPATH_W-1:0]   mac_sum;
   logic signed [DATAPATH_W-1:0]   acc;
   logic signed [DATAPATH_W-1:0]   result;
   logic signed [2*DATAPATH_W-1:0] mac_prod;

   always_ff @(posedge clk) begin
      if (cfg_valid) begin
         case (cfg_addr)
            REG_IN_ADDR:  in_base  <= cfg_wdata;
            REG_OUT_ADDR: out_base <= cfg_wdata;
            REG_N_OUT:    n_out    <= cfg_wdata;
            default: ;
         endcase
      end
   end

   // reads stall only when a finished sum would find the result slot full
   assign last_mac = (mac_cnt == CNT_W'(N_MACS - 1));
   assign rd_valid = active & started & (rd_out_cnt != n_out) & ~(last_mac & res_full);
   assign rd_addr  = in_ptr;
   assign rd_fire  = rd_valid & rd_ready;

   assign wr_valid = res_full;
   assign wr_addr  = out_ptr;
   assign wr_wdata = {{(DATA_W-DATAPATH_W){result[DATAPATH_W-1]}}, result};
   assign wr_fire  = res_full & wr_ready;

   // mac, truncated to the datapath width
   assign mac_w    = flow_in_weight[mac_cnt*DATAPATH_W +: DATAPATH_W];
   assign mac_x    = rd_rdata[DATAPATH_W-1:0];
   assign mac_base = (mac_cnt == '0) ? flow_in_bias : acc;
   assign mac_prod = mac_w * mac_x;
   assign mac_sum  = mac_base + mac_prod[DATAPATH_W-1:0];

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         active     <= 1'b0;
         started    <= 1'b0;
         done       <= 1'b0;
         res_full   <= 1'b0;
         mac_cnt    <= '0;
         rd_out_cnt <= '0;
         wr_cnt     <= '0;
         in_ptr     <= '0;
         out_ptr    <= '0;
      end else if (clear) begin
         active   <= 1'b0;
         started  <= 1'b0;
         done     <= 1'b0;
         res_full <= 1'b0;
      end else if (run) begin
         active     <= 1'b1;
         started    <= 1'b0;
         done       <= 1'b0;
         res_full   <= 1'b0;
         mac_cnt    <= '0;
         rd_out_cnt <= '0;
         wr_cnt     <= '0;
         in_ptr     <= in_base;
         out_ptr    <= out_base;
      end else if (active) begin
         // weights are valid once the read unit reports done
         if (!started && flow_in_done) begin
            started <= 1'b1;
            if (n_out == '0) begin
               active <= 1'b0;
               done   <= 1'b1;
            end
         end
         if (wr_fire) begin
            res_full <= 1'b0;
            out_ptr  <= out_ptr + 1'b1;
            wr_cnt   <= wr_cnt + 1'b1;
            if (wr_cnt + 1'b1 == n_out) begin
               active <= 1'b0;
               done   <= 1'b1;
            end
         end
         if (rd_fire) begin
            in_ptr <= in_ptr + 1'b1;
            if (last_mac) begin
               mac_cnt    <= '0;
               rd_out_cnt <= rd_out_cnt + 1'b1;
               res_full   <= 1'b1;
            end else begin
               mac_cnt <= mac_cnt + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rd_fire) begin
         acc <= mac_sum;
         if (last_mac)
            result <= mac_sum;
      end
   end

   wr_hold: assert property (@(posedge clk) disable iff (rst)
      wr_valid && !wr_ready && !clear && !run
      |=> wr_valid && $stable(wr_addr) && $stable(wr_wdata))
      else $error("result write changed before wr_ready");

endmodule

`default_nettype wire

//--- hdl/xyolo_read.sv
`timescale 1ns/1ps
`default_nettype none

module xyolo_read import xversat_cfg_pkg::*; #(
   parameter int DATA_W     = 32,
   parameter int DATAPATH_W = 16,
   parameter int N_MACS     = 4
) (
   input  wire                          clk,
   input  wire                          rst,
   input  wire                          clear,
   input  wire                          run,
   input  wire                          cfg_valid,
   input  wire  [REG_IDX_W-1:0]         cfg_addr,
   input  wire  [DATA_W-1:0]            cfg_wdata,
   output logic                         done,
   output logic                         db_valid,
   output logic [DATA_W-1:0]            db_addr,
   output logic [DATA_W-1:0]            db_wdata,
   output logic                         db_wstrb,
   input  wire                          db_ready,
   input  wire  [DATA_W-1:0]            db_rdata,
   output logic [DATAPATH_W-1:0]        flow_out_bias,
   output logic [N_MACS*DATAPATH_W-1:0] flow_out_weight
);

   // fetch 0 is the bias, fetches 1..N_MACS the weights
   localparam int CNT_W = $clog2(N_MACS + 1);

   logic [DATA_W-1:0]                  bias_base;
   logic [DATA_W-1:0]                  weight_base;
   logic [CNT_W-1:0]                   cnt;
   logic                               busy;
   logic                               fire;
   logic [DATAPATH_W-1:0]              bias;
   logic [N_MACS-1:0][DATAPATH_W-1:0]  weight;

   always_ff @(posedge clk) begin
      if (cfg_valid) begin
         case (cfg_addr)
            REG_BIAS_ADDR:   bias_base   <= cfg_wdata;
            REG_WEIGHT_ADDR: weight_base <= cfg_wdata;
            default: ;
         endcase
      end
   end

   // read-only requester
   assign db_valid = busy;
   assign db_addr  = (cnt == '0) ? bias_base : weight_base + DATA_W'(cnt) - 1'b1;
   assign db_wdata = '0;
   assign db_wstrb = 1'b0;
   assign fire     = busy & db_ready;

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         busy <= 1'b0;
         done <= 1'b0;
         cnt  <= '0;
      end else if (clear) begin
         busy <= 1'b0;
         done <= 1'b0;
      end else if (run) begin
         busy <= 1'b1;
         done <= 1'b0;
         cnt  <= '0;
      end else if (fire) begin
         if (cnt == CNT_W'(N_MACS)) begin
            busy <= 1'b0;
            done <= 1'b1;
         end else begin
            cnt <= cnt + 1'b1;
         end
      end
   end

   // only the low datapath bits of each word are kept
   always_ff @(posedge clk) begin
      if (fire) begin
         if (cnt == '0)
            bias <= db_rdata[DATAPATH_W-1:0];
         else
            weight[cnt - 1'b1] <= db_rdata[DATAPATH_W-1:0];
      end
   end

   assign flow_out_bias   = bias;
   assign flow_out_weight = weight;

endmodule

`default_nettype wire

//--- hdl/cfg_split.sv
`timescale 1ns/1ps
`default_nettype none

module cfg_split import xversat_cfg_pkg::*; #(
   parameter int ADDR_W = 32,
   parameter int DATA_W = 32
) (
   input  wire                  clk,
   input  wire                  rst,
   input  wire                  valid,
   input  wire  [ADDR_W-1:0]    addr,
   input  wire                  wstrb,
   input  wire  [DATA_W-1:0]    wdata,
   output logic                 cfg_valid_read,
   output logic                 cfg_valid_write,
   output logic [REG_IDX_W-1:0] cfg_addr,
   output logic [DATA_W-1:0]    cfg_wdata,
   output logic                 run,
   output logic                 clear
);

   cpu_addr_t  cpu_addr;
   logic       cpu_wr;
   logic       cfg_wr;
   logic       run_req;
   logic [1:0] run_q;

   assign cpu_addr = addr;
   assign cpu_wr   = valid & wstrb;

   // config writes, routed by unit select
   assign cfg_wr          = cpu_wr & ~cpu_addr.cfg.ctrl;
   assign cfg_valid_read  = cfg_wr & (cpu_addr.cfg.unit == UNIT_READ);
   assign cfg_valid_write = cfg_wr & (cpu_addr.cfg.unit == UNIT_WRITE);
   assign cfg_addr        = cpu_addr.cfg.reg_idx;
   assign cfg_wdata       = wdata;

   // control writes
   assign run_req = cpu_wr & cpu_addr.ctl.ctrl & ~cpu_addr.ctl.clr;
   assign clear   = cpu_wr & cpu_addr.ctl.ctrl & cpu_addr.ctl.clr;

   // two stages, then one pulse per request however long it is held
   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         run_q <= 2'b00;
         run   <= 1'b0;
      end else begin
         run_q <= {run_q[0], run_req};
         run   <= run_q[0] & ~run_q[1];
      end
   end

   run_single: assert property (@(posedge clk) disable iff (rst) run |=> !run)
      else $error("run held for more than one cycle");

endmodule

`default_nettype wire

//--- hdl/xversat_bus_pkg.sv
`default_nettype none

package xversat_bus_pkg;

   // databus requesters sharing the memory port
   localparam int N_REQ = 3;

   // weight and bias fetch
   localparam int PORT_READ = 0;

   // input vector fetch of the write unit
   localparam int PORT_WRITE_RD = 1;

   // result store of the write unit
   localparam int PORT_WRITE_WR = 2;

endpackage

`default_nettype wire

//--- hdl/xversat_cfg_pkg.sv
`default_nettype none

package xversat_cfg_pkg;

   // cpu address word width and register index width
   localparam int CPU_ADDR_W = 32;
   localparam int REG_IDX_W  = 4;

   // unit select codes
   localparam logic [1:0] UNIT_READ  = 2'd0;
   localparam logic [1:0] UNIT_WRITE = 2'd1;

   // read unit registers
   localparam logic [REG_IDX_W-1:0] REG_BIAS_ADDR   = 4'd0;
   localparam logic [REG_IDX_W-1:0] REG_WEIGHT_ADDR = 4'd1;

   // write unit registers
   localparam logic [REG_IDX_W-1:0] REG_IN_ADDR  = 4'd0;
   localparam logic [REG_IDX_W-1:0] REG_OUT_ADDR = 4'd1;
   localparam logic [REG_IDX_W-1:0] REG_N_OUT    = 4'd2;

   // config write, ctrl flag low
   typedef struct packed {
      logic                  ctrl;
      logic [1:0]            unit;
      logic [CPU_ADDR_W-8:0] rsvd;
      logic [REG_IDX_W-1:0]  reg_idx;
   } cfg_view_t;

   // run or clear, ctrl flag high
   typedef struct packed {
      logic                  ctrl;
      logic                  clr;
      logic [CPU_ADDR_W-3:0] rsvd;
   } ctl_view_t;

   // the same address word seen both ways
   typedef union packed {
      cfg_view_t cfg;
      ctl_view_t ctl;
   } cpu_addr_t;

endpackage

`default_nettype wire
